// ==== design/fp_free_list.sv ====
// FP free list: circular buffer of free physical registers with per-checkpoint heads
`include "fp_rename_config.svh"

module fp_free_list import fp_rename_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            read_head_i,          // Take the head register
    input  logic            take_checkpoint_i,    // Save head and count after this cycle
    input  logic            recover_i,            // Return to a saved checkpoint
    input  logic            delete_checkpoint_i,  // Retire the oldest checkpoint
    input  checkpoint_ptr_t recover_checkpoint_i, // Label to return to
    input  commit_free_t    free_i,               // Registers released by commit
    output phfreg_t         new_register_o,       // Register handed out on a read
    output checkpoint_ptr_t checkpoint_o,         // Working copy label
    output logic            empty_o,              // Nothing to hand out this cycle
    output logic            out_of_checkpoints_o  // All spare copies in use
);

    localparam int NUM_ENTRIES = `FP_NUM_PHYS_REGS - `FP_NUM_ISA_REGS; // 32 spare registers

    typedef logic [$clog2(NUM_ENTRIES)-1:0]        entry_ptr_t;  // Table index
    typedef logic [$clog2(NUM_ENTRIES):0]          reg_count_t;  // 0..NUM_ENTRIES
    typedef logic [$clog2(`FP_NUM_CHECKPOINTS):0] ckpt_count_t; // Live checkpoints

    //////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////

    phfreg_t         register_table [NUM_ENTRIES];        // Free register storage
    entry_ptr_t      head [`FP_NUM_CHECKPOINTS];          // Head per copy
    reg_count_t      free_count [`FP_NUM_CHECKPOINTS];    // Free registers per copy
    entry_ptr_t      tail;                                // Shared by all copies
    checkpoint_ptr_t version_head;                        // Working copy
    checkpoint_ptr_t version_tail;                        // Oldest live checkpoint
    ckpt_count_t     num_checkpoints;

    logic            write_en_0, write_en_1;
    logic [1:0]      num_freed;
    logic            read_en;
    logic            checkpoint_en;
    checkpoint_ptr_t next_version;
    checkpoint_ptr_t tail_version_next;
    reg_count_t      cur_count_next;

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    assign write_en_0 = free_i.valid[0];
    assign write_en_1 = free_i.valid[1];
    assign num_freed  = {1'b0, write_en_0} + {1'b0, write_en_1};

    // A read needs a stored register or one arriving this cycle
    assign read_en = read_head_i & ~recover_i
                   & ((free_count[version_head] != '0) | write_en_0 | write_en_1);

    // Only with a spare copy left
    assign checkpoint_en = take_checkpoint_i & ~out_of_checkpoints_o & ~recover_i;

    assign next_version      = version_head + 1'b1;
    assign tail_version_next = version_tail + checkpoint_ptr_t'(delete_checkpoint_i);

    // Working count after frees and the read of this cycle
    assign cur_count_next = free_count[version_head] + reg_count_t'(num_freed)
                          - reg_count_t'(read_en);

    //////////////////////////////////////////////////
    // Sequential update
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            tail            <= '0;
            version_head    <= '0;
            version_tail    <= '0;
            num_checkpoints <= '0;
            for (int c = 0; c < `FP_NUM_CHECKPOINTS; c++) begin
                head[c]       <= '0;
                free_count[c] <= reg_count_t'(NUM_ENTRIES); // All spares free
            end
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                register_table[i] <= phfreg_t'(`FP_NUM_ISA_REGS + i); // 32..63 in order
            end
        end else begin
            // Freed registers go in at the tail, in port order
            if (write_en_0) begin
                register_table[tail] <= free_i.phys_reg[0];
                if (write_en_1) begin
                    register_table[tail + 1'b1] <= free_i.phys_reg[1];
                end
            end else if (write_en_1) begin
                register_table[tail] <= free_i.phys_reg[1];
            end
            tail <= tail + entry_ptr_t'(num_freed);

            // Frees count in every copy, saved or not
            for (int c = 0; c < `FP_NUM_CHECKPOINTS; c++) begin
                free_count[c] <= free_count[c] + reg_count_t'(num_freed);
            end

            version_tail <= tail_version_next; // Oldest checkpoint retired

            if (recover_i) begin
                // Saved copy becomes the working one; newer copies are dropped
                version_head    <= recover_checkpoint_i;
                num_checkpoints <= ckpt_count_t'(checkpoint_ptr_t'(recover_checkpoint_i
                                                                   - tail_version_next));
            end else begin
                num_checkpoints <= num_checkpoints + ckpt_count_t'(checkpoint_en)
                                 - ckpt_count_t'(delete_checkpoint_i);
                head[version_head]       <= head[version_head] + entry_ptr_t'(read_en);
                free_count[version_head] <= cur_count_next; // Read only hits the working copy

                // Current copy is frozen, work continues in the next slot
                if (checkpoint_en) begin
                    version_head             <= next_version;
                    head[next_version]       <= head[version_head] + entry_ptr_t'(read_en);
                    free_count[next_version] <= cur_count_next;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    // Empty list: hand a register being freed straight through
    always_comb begin
        if (free_count[version_head] == '0) begin
            new_register_o = write_en_0 ? free_i.phys_reg[0] : free_i.phys_reg[1];
        end else begin
            new_register_o = register_table[head[version_head]];
        end
    end

    assign checkpoint_o         = version_head;
    assign empty_o              = (free_count[version_head] == '0) & ~write_en_0 & ~write_en_1;
    assign out_of_checkpoints_o = (num_checkpoints == ckpt_count_t'(`FP_NUM_CHECKPOINTS - 1));

endmodule

// ==== design/fp_rename_config.svh ====
// FP rename configuration: register file sizes and checkpoint depth
`ifndef FP_RENAME_CONFIG_SVH
`define FP_RENAME_CONFIG_SVH

//////////////////////////////////////////////////
// Register files
//////////////////////////////////////////////////

// Physical FP registers in the core
`define FP_NUM_PHYS_REGS 64

// Architectural FP registers (f0..f31)
`define FP_NUM_ISA_REGS 32

//////////////////////////////////////////////////
// Checkpointing
//////////////////////////////////////////////////

// Copies of free list and map, one of them is always the working copy.
// Must stay a power of two, the labels wrap around.
`define FP_NUM_CHECKPOINTS 4

`endif

// ==== design/fp_rename_map.sv ====
// FP rename map: checkpointed arch-to-phys table with registered rename response
`include "fp_rename_config.svh"

module fp_rename_map import fp_rename_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  rename_req_t     req_i,
    input  logic            recover_i,
    input  checkpoint_ptr_t recover_checkpoint_i,
    input  checkpoint_ptr_t checkpoint_i,         // Working copy label from the free list
    input  phfreg_t         new_register_i,       // Head of the free list
    input  logic            empty_i,
    input  logic            out_of_checkpoints_i,
    output logic            ready_o,
    output logic            read_head_o,          // Consume the free-list head
    output logic            take_checkpoint_o,
    output rename_resp_t    resp_o
);

    phfreg_t map_table [`FP_NUM_CHECKPOINTS][`FP_NUM_ISA_REGS]; // One map per copy

    checkpoint_ptr_t active_slot;
    checkpoint_ptr_t next_slot;
    logic            accept;
    phfreg_t         src1_phys, src2_phys, old_dst_phys;

    // Response register
    logic            resp_valid_q;
    phfreg_t         src1_q, src2_q, dst_q, old_dst_q;
    checkpoint_ptr_t checkpoint_q;

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    // Hold on recover, on an empty list for a write, and with no spare copy
    assign ready_o = ~recover_i
                   & (~req_i.write_dst | ~empty_i)
                   & (~req_i.do_checkpoint | ~out_of_checkpoints_i);

    assign accept            = req_i.valid & ready_o;
    assign read_head_o       = accept & req_i.write_dst;
    assign take_checkpoint_o = accept & req_i.do_checkpoint;

    // Restored copy as soon as the recover is signalled
    assign active_slot = recover_i ? recover_checkpoint_i : checkpoint_i;
    assign next_slot   = active_slot + 1'b1;

    // Lookups see the map before this request's own write
    assign src1_phys    = map_table[active_slot][req_i.src1];
    assign src2_phys    = map_table[active_slot][req_i.src2];
    assign old_dst_phys = map_table[active_slot][req_i.dst];

    //////////////////////////////////////////////////
    // Map update
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int c = 0; c < `FP_NUM_CHECKPOINTS; c++) begin
                for (int a = 0; a < `FP_NUM_ISA_REGS; a++) begin
                    map_table[c][a] <= phfreg_t'(a); // Identity
                end
            end
        end else begin
            // Copy whole map; the dst write below overrides its entry
            if (take_checkpoint_o) begin
                for (int a = 0; a < `FP_NUM_ISA_REGS; a++) begin
                    map_table[next_slot][a] <= map_table[active_slot][a];
                end
            end
            if (read_head_o) begin
                map_table[active_slot][req_i.dst] <= new_register_i; // Frozen copy keeps it too
                if (take_checkpoint_o) begin
                    map_table[next_slot][req_i.dst] <= new_register_i;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= accept; // One cycle per accepted request
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            src1_q       <= src1_phys;
            src2_q       <= src2_phys;
            dst_q        <= req_i.write_dst ? new_register_i : old_dst_phys; // No write keeps it
            old_dst_q    <= old_dst_phys;
            checkpoint_q <= active_slot;     // Frozen copy if a checkpoint was taken
        end
    end

    assign resp_o = '{valid:        resp_valid_q,
                      src1_phys:    src1_q,
                      src2_phys:    src2_q,
                      dst_phys:     dst_q,
                      old_dst_phys: old_dst_q,
                      checkpoint:   checkpoint_q};

endmodule

// ==== design/fp_rename_pkg.sv ====
// FP rename types: register numbers, checkpoint labels and the rename/commit bundles
`include "fp_rename_config.svh"

package fp_rename_pkg;

    typedef logic [$clog2(`FP_NUM_PHYS_REGS)-1:0]   phfreg_t;         // Physical FP register
    typedef logic [$clog2(`FP_NUM_ISA_REGS)-1:0]    arfreg_t;         // Architectural FP register
    typedef logic [$clog2(`FP_NUM_CHECKPOINTS)-1:0] checkpoint_ptr_t; // Checkpoint label

    // Request from the front end
    typedef struct packed {
        logic    valid;         // Request present
        arfreg_t src1;          // First source
        arfreg_t src2;          // Second source
        arfreg_t dst;           // Destination
        logic    write_dst;     // Destination is written, takes a new register
        logic    do_checkpoint; // Take a checkpoint after this rename
    } rename_req_t;

    // Response, one cycle after acceptance
    typedef struct packed {
        logic            valid;
        phfreg_t         src1_phys;
        phfreg_t         src2_phys;
        phfreg_t         dst_phys;     // New register for the destination
        phfreg_t         old_dst_phys; // Previous mapping, freed at commit
        checkpoint_ptr_t checkpoint;   // Label to recover to
    } rename_resp_t;

    // Registers released by commit
    typedef struct packed {
        logic [1:0]    valid;
        phfreg_t [1:0] phys_reg;
    } commit_free_t;

endpackage

// ==== design/fp_rename_unit.sv ====
// FP rename unit: map and free list joined into one rename stage
module fp_rename_unit import fp_rename_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  rename_req_t     req_i,                // From the front end
    output logic            ready_o,
    output rename_resp_t    resp_o,               // Valid one cycle after acceptance
    input  commit_free_t    free_i,               // From commit
    input  logic            recover_i,            // Mispredict pulse
    input  checkpoint_ptr_t recover_checkpoint_i,
    input  logic            delete_checkpoint_i,  // Oldest branch resolved
    output logic            out_of_checkpoints_o
);

    //////////////////////////////////////////////////
    // Map to free list
    //////////////////////////////////////////////////

    logic            read_head;       // Accepted request writes a dst
    logic            take_checkpoint; // Accepted request takes a checkpoint
    phfreg_t         new_register;
    logic            empty;
    checkpoint_ptr_t checkpoint;      // Working copy label
    logic            out_of_checkpoints;

    fp_rename_map rename_map (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req_i),
        .recover_i            (recover_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .checkpoint_i         (checkpoint),
        .new_register_i       (new_register),
        .empty_i              (empty),
        .out_of_checkpoints_i (out_of_checkpoints),
        .ready_o              (ready_o),
        .read_head_o          (read_head),
        .take_checkpoint_o    (take_checkpoint),
        .resp_o               (resp_o)
    );

    fp_free_list free_list (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .read_head_i          (read_head),
        .take_checkpoint_i    (take_checkpoint),
        .recover_i            (recover_i),
        .delete_checkpoint_i  (delete_checkpoint_i),
        .recover_checkpoint_i (recover_checkpoint_i),
        .free_i               (free_i),
        .new_register_o       (new_register),
        .checkpoint_o         (checkpoint),
        .empty_o              (empty),
        .out_of_checkpoints_o (out_of_checkpoints)
    );

    assign out_of_checkpoints_o = out_of_checkpoints; // Front end sees the same level

endmodule

// ==== fp_rename.f ====
+incdir+design
design/fp_rename_pkg.sv
design/fp_free_list.sv
design/fp_rename_map.sv
design/fp_rename_unit.sv
test/fp_rename_assert.sv
test/fp_rename_checker.sv
test/fp_rename_tb.sv

// ==== test/fp_rename_assert.sv ====
// FP free list assertions: register range, reads on an empty list, checkpoint limit
`include "fp_rename_config.svh"

module fp_rename_assert import fp_rename_pkg::*; (
    input logic         clk_i,
    input logic         rstn_i,
    input logic         read_head_i,
    input logic         take_checkpoint_i,
    input commit_free_t free_i,
    input phfreg_t      new_register_o,
    input logic         empty_o,
    input logic         out_of_checkpoints_o
);

    int fail_count = 0; // Read by the testbench for its closing line

    // Architectural registers are never on the free list
    reg_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        read_head_i |-> new_register_o >= phfreg_t'(`FP_NUM_ISA_REGS))
        else begin $error("Free list handed out register %0d", new_register_o); fail_count++; end

    // A read needs a stored register or one freed in the same cycle
    empty_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
        read_head_i |-> !empty_o || free_i.valid != 2'b00)
        else begin $error("Read from an empty free list"); fail_count++; end

    ckpt_limit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        out_of_checkpoints_o |-> !take_checkpoint_i) // Held by ready_o upstream
        else begin $error("Checkpoint taken with no spare copy"); fail_count++; end

endmodule

bind fp_free_list fp_rename_assert free_list_checks (.*);

// ==== test/fp_rename_cases.txt ====
# name op rep, rename/hold: src1 src2 dst write ckpt, then expected src1 src2 dst old_dst ckpt
# free: mask reg0 reg1; recover: label; hex; rep steps dst, exp dst and exp old_dst by one
reset_first  rename  1  01 02 03 1 0  01 02 20 03 0
raw_same     rename  1  03 03 03 1 0  20 20 21 20 0
raw_b2b      rename  1  03 04 04 1 0  21 04 22 04 0
ckpt_take    rename  1  03 04 05 1 1  21 22 23 05 0
spec_a       rename  1  05 03 03 1 0  23 21 24 21 1
spec_b       rename  1  03 00 07 1 0  24 00 25 07 1
mispredict   recover 1  00 00 00 0 0  00 00 00 00 0
after_rec    rename  1  03 07 08 1 0  21 07 24 08 0
ckpt_1       rename  1  08 08 09 1 1  24 24 25 09 0
ckpt_2       rename  1  09 01 09 1 1  25 01 26 25 1
ckpt_3       rename  1  09 02 0a 1 1  26 02 27 0a 2
ckpt_full    hold    1  00 00 0b 1 1  00 00 00 00 0
retire       delete  1  00 00 00 0 0  00 00 00 00 0
ckpt_4       rename  1  0a 09 0b 1 1  27 26 28 0b 3
drain_hi     rename  14 03 04 0c 1 0  21 22 29 0c 0
drain_lo     rename  3  0c 1f 00 1 0  29 3c 3d 00 0
list_empty   hold    1  00 00 05 1 0  00 00 00 00 0
commit_two   free    1  03 25 20 0 0  00 00 00 00 0
reuse_a      rename  1  09 09 03 1 0  26 26 25 21 0
reuse_b      rename  1  03 00 04 1 0  25 3d 20 22 0
final_idle   idle    1  00 00 00 0 0  00 00 00 00 0

// ==== test/fp_rename_checker.sv ====
// FP rename response checker: matches each DUT response with the queued expectation
`include "fp_rename_config.svh"

module fp_rename_checker import fp_rename_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  rename_req_t     req_i,          // Request as the DUT sees it
    input  logic            ready_i,
    input  rename_resp_t    resp_i,
    input  logic            recover_i,
    input  checkpoint_ptr_t recover_ckpt_i,
    input  logic            delete_i,
    input  logic            out_of_ckpts_i,
    input  logic            exp_valid_i,    // Request carries an expected response
    input  logic            exp_held_i,     // Request must see ready low
    input  rename_resp_t    exp_resp_i,
    input  logic [127:0]    exp_name_i,     // Name of the current step, right-justified text
    input  logic            end_i,          // Stimulus over
    output int              error_count_o
);

    rename_resp_t    expected_q [$]; // One entry per accepted rename
    logic [127:0]    name_q [$];
    checkpoint_ptr_t live_q [$];     // Labels of live checkpoints, oldest first
    rename_resp_t    expected;
    logic [127:0]    name;
    int              errors   = 0;
    logic            end_seen = 1'b0;

    assign error_count_o = errors;

    task automatic compare_field(input logic [127:0] test, input string field,
                                 input int exp_val, input int act_val);
        if (exp_val != act_val) begin
            $display("MISMATCH %0s %s: expected %0h, actual %0h", test, field, exp_val, act_val);
            errors++;
        end
    endtask

    // Acceptance is seen before the edge updates the DUT
    always @(posedge clk_i) begin
        if (rstn_i && req_i.valid && ready_i && exp_valid_i) begin
            expected_q.push_back(exp_resp_i);
            name_q.push_back(exp_name_i);
        end
        if (rstn_i) begin
            if (delete_i && live_q.size() != 0) begin
                void'(live_q.pop_front()); // Oldest checkpoint retired
            end
            if (recover_i) begin
                // Drop newer checkpoints and the recovered one itself
                while (live_q.size() != 0 && live_q[$] != recover_ckpt_i) begin
                    void'(live_q.pop_back());
                end
                if (live_q.size() != 0) begin
                    void'(live_q.pop_back());
                end
            end else if (req_i.valid && ready_i && req_i.do_checkpoint) begin
                live_q.push_back(exp_resp_i.checkpoint);
            end
        end
    end

    //////////////////////////////////////////////////
    // Compare at the falling edge, outputs settled
    //////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (rstn_i && resp_i.valid) begin
            if (expected_q.size() == 0) begin
                $display("Rename response with dst_phys %0h arrived with none expected",
                         resp_i.dst_phys);
                errors++;
            end else begin
                expected = expected_q.pop_front();
                name     = name_q.pop_front();
                compare_field(name, "src1_phys", expected.src1_phys, resp_i.src1_phys);
                compare_field(name, "src2_phys", expected.src2_phys, resp_i.src2_phys);
                compare_field(name, "dst_phys", expected.dst_phys, resp_i.dst_phys);
                compare_field(name, "old_dst_phys", expected.old_dst_phys, resp_i.old_dst_phys);
                compare_field(name, "checkpoint", expected.checkpoint, resp_i.checkpoint);
            end
        end
        if (rstn_i) begin
            // Three live checkpoints use up every spare copy
            compare_field(exp_name_i, "out_of_checkpoints",
                          int'(live_q.size() == `FP_NUM_CHECKPOINTS - 1), int'(out_of_ckpts_i));
            if (exp_held_i) begin
                compare_field(exp_name_i, "ready", 0, int'(ready_i));
            end
        end
        if (end_i && !end_seen) begin
            end_seen = 1'b1;
            if (expected_q.size() != 0) begin // Accepted but never answered
                $display("%0d expected rename responses never arrived", expected_q.size());
                errors += expected_q.size();
            end
        end
    end

endmodule

// ==== test/fp_rename_tb.sv ====
// FP rename testbench: replays the case file against the rename unit
module fp_rename_tb import fp_rename_pkg::*; ();

    logic            clk  = 1'b0;
    logic            rstn = 1'b0;
    rename_req_t     req;
    logic            ready;
    rename_resp_t    resp;
    commit_free_t    free_regs;
    logic            recover, delete_ckpt, out_of_ckpts;
    checkpoint_ptr_t recover_ckpt;
    logic            exp_valid, exp_held, stim_done; // To the checker
    rename_resp_t    exp_resp;
    logic [127:0]    exp_name;
    int              checker_errors;
    int              other_errors   = 0;
    int              timeout_cycles = 0;
    string           lines [$];              // Case lines without comments

    always #50 clk = ~clk;

    fp_rename_unit UUT (
        .clk_i(clk), .rstn_i(rstn), .req_i(req), .ready_o(ready), .resp_o(resp),
        .free_i(free_regs), .recover_i(recover), .recover_checkpoint_i(recover_ckpt),
        .delete_checkpoint_i(delete_ckpt), .out_of_checkpoints_o(out_of_ckpts)
    );

    fp_rename_checker response_check (
        .clk_i(clk), .rstn_i(rstn), .req_i(req), .ready_i(ready), .resp_i(resp),
        .recover_i(recover), .recover_ckpt_i(recover_ckpt), .delete_i(delete_ckpt),
        .out_of_ckpts_i(out_of_ckpts), .exp_valid_i(exp_valid), .exp_held_i(exp_held),
        .exp_resp_i(exp_resp), .exp_name_i(exp_name), .end_i(stim_done),
        .error_count_o(checker_errors)
    );

    task automatic apply_defaults(); // Pulses last one cycle
        req          <= '0;
        free_regs    <= '0;
        recover      <= 1'b0;
        recover_ckpt <= '0;
        delete_ckpt  <= 1'b0;
        exp_valid    <= 1'b0;
        exp_held     <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Case file, reset, stimulus
    //////////////////////////////////////////////////

    initial begin
        int           fd;
        int           rep;
        int           total;
        int           f [10];
        string        line;
        logic [127:0] name;
        logic [63:0]  op;
        apply_defaults();
        exp_resp  <= '0;
        exp_name  <= '0;
        stim_done <= 1'b0;
        total = 0;
        fd = $fopen("test/fp_rename_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file test/fp_rename_cases.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                    void'($sscanf(line, "%s %s %h", name, op, rep));
                    total += (rep > 0) ? rep : 1;
                end
            end
            $fclose(fd);
        end
        timeout_cycles = total * 20; // Starts the watchdog
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s %s %h %h %h %h %h %h %h %h %h %h %h", name, op, rep,
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]));
            for (int r = 0; r < ((rep > 0) ? rep : 1); r++) begin
                @(posedge clk);
                apply_defaults();
                exp_name <= name;
                case (op)
                    "rename", "hold": begin
                        req <= '{valid: 1'b1, src1: arfreg_t'(f[0]), src2: arfreg_t'(f[1]),
                                 dst: arfreg_t'(f[2] + r), write_dst: f[3][0],
                                 do_checkpoint: f[4][0]};
                        exp_valid <= (op == "rename");
                        exp_held  <= (op == "hold");
                        exp_resp  <= '{valid: 1'b1, src1_phys: phfreg_t'(f[5]),
                                       src2_phys: phfreg_t'(f[6]), dst_phys: phfreg_t'(f[7] + r),
                                       old_dst_phys: phfreg_t'(f[8] + r),
                                       checkpoint: checkpoint_ptr_t'(f[9])};
                        @(negedge clk);
                        while (op == "rename" && !ready) @(negedge clk); // Held by back-pressure
                    end
                    "free":    free_regs <= '{valid: f[0][1:0],
                                              phys_reg: {phfreg_t'(f[2]), phfreg_t'(f[1])}};
                    "recover": begin
                        recover      <= 1'b1;
                        recover_ckpt <= checkpoint_ptr_t'(f[0]);
                    end
                    "delete":  delete_ckpt <= 1'b1;
                    "idle":    ;
                    default: begin
                        $display("%0s: unknown operation in the case file", name);
                        other_errors++;
                    end
                endcase
            end
        end
        @(posedge clk);
        apply_defaults();
        repeat (3) @(posedge clk); // Last response drains
        stim_done <= 1'b1;
        repeat (2) @(posedge clk);
        $display("Errors: %0d checker, %0d stimulus, %0d assertion", checker_errors,
                 other_errors, UUT.free_list.free_list_checks.fail_count);
        if (checker_errors + other_errors + UUT.free_list.free_list_checks.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog, 20 cycles per operation after reset
    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles + 10) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
